// ==== verilog/eth_rx_pkg.sv ====
`default_nettype none

package eth_rx_pkg;

   localparam int MAC_W = 48;

   // destination + source + length
   localparam int HDR_BYTES = 14;
   localparam int FCS_BYTES = 4;

   localparam logic [3:0] PREAMBLE_NIBBLE = 4'h5;
   localparam logic [3:0] SFD_HIGH_NIBBLE = 4'hD;

   // written msb first, the crc register holds it bit reversed
   localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

   typedef enum logic [1:0] {
      HUNT,
      PREAMBLE,
      LOW_NIBBLE,
      HIGH_NIBBLE
   } front_state_t;

   typedef enum logic [2:0] {
      IDLE,
      DEST,
      SRC,
      LEN,
      PAYLOAD,
      FCS,
      DROP
   } parse_state_t;

endpackage

`default_nettype wire

// ==== verilog/eth_mii_rx_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_mii_rx_frontend (
   input  wire        RX_CLK,
   input  wire        rst,
   input  wire        rx_dv,
   input  wire  [3:0] rx_data,
   output logic       rx_rst,
   output logic [7:0] rx_byte,
   output logic       byte_valid,
   output logic       frame_start,
   output logic       frame_end
);

   logic                     rst_meta;
   logic [3:0]               low_nibble_q;
   eth_rx_pkg::front_state_t state_q;

   // two stage reset sync, async assert
   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         rst_meta <= 1'b1;
         rx_rst   <= 1'b1;
      end else begin
         rst_meta <= 1'b0;
         rx_rst   <= rst_meta;
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state_q     <= eth_rx_pkg::HUNT;
         byte_valid  <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
      end else begin
         byte_valid  <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
         if (!rx_dv) begin
            // only close a frame that was opened by the delimiter
            frame_end <= (state_q == eth_rx_pkg::LOW_NIBBLE) ||
                         (state_q == eth_rx_pkg::HIGH_NIBBLE);
            state_q   <= eth_rx_pkg::HUNT;
         end else begin
            case (state_q)
               eth_rx_pkg::HUNT: begin
                  if (rx_data == eth_rx_pkg::PREAMBLE_NIBBLE) begin
                     state_q <= eth_rx_pkg::PREAMBLE;
                  end
               end
               eth_rx_pkg::PREAMBLE: begin
                  if (rx_data == eth_rx_pkg::SFD_HIGH_NIBBLE) begin
                     state_q     <= eth_rx_pkg::LOW_NIBBLE;
                     frame_start <= 1'b1;
                  end else if (rx_data != eth_rx_pkg::PREAMBLE_NIBBLE) begin
                     state_q <= eth_rx_pkg::HUNT;
                  end
               end
               eth_rx_pkg::LOW_NIBBLE: begin
                  state_q <= eth_rx_pkg::HIGH_NIBBLE;
               end
               eth_rx_pkg::HIGH_NIBBLE: begin
                  byte_valid <= 1'b1;
                  state_q    <= eth_rx_pkg::LOW_NIBBLE;
               end
               default: begin
                  state_q <= eth_rx_pkg::HUNT;
               end
            endcase
         end
      end
   end

   // low nibble arrives first on the wire
   always_ff @(posedge RX_CLK) begin
      if (rx_dv && state_q == eth_rx_pkg::LOW_NIBBLE) begin
         low_nibble_q <= rx_data;
      end
      if (rx_dv && state_q == eth_rx_pkg::HIGH_NIBBLE) begin
         rx_byte <= {rx_data, low_nibble_q};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/eth_crc32.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_crc32 (
   input  wire       RX_CLK,
   input  wire       rx_rst,
   input  wire       crc_init,
   input  wire       byte_valid,
   input  wire [7:0] rx_byte,
   output logic      crc_ok
);

   // reflected form of 0x04C11DB7
   localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;

   logic [31:0] crc_q;
   logic [31:0] crc_rev;

   // one byte, lsb first
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'd0, data};
      for (int i = 0; i < 8; i++) begin
         if (c[0]) begin
            c = (c >> 1) ^ CRC_POLY_REFL;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_q <= '1;
      end else if (crc_init) begin
         crc_q <= '1;
      end else if (byte_valid) begin
         crc_q <= crc_byte(crc_q, rx_byte);
      end
   end

   // register runs lsb first, residue constant is msb first
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         crc_rev[i] = crc_q[31-i];
      end
   end

   assign crc_ok = (crc_rev == eth_rx_pkg::CRC_RESIDUE);

endmodule

`default_nettype wire

// ==== verilog/eth_rx_parser.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_rx_parser #(
   parameter int BUF_ADDR_W = 11
) (
   input  wire                          RX_CLK,
   input  wire                          rx_rst,
   input  wire                          frame_start,
   input  wire                          frame_end,
   input  wire                          byte_valid,
   input  wire  [7:0]                   rx_byte,
   input  wire                          crc_ok,
   input  wire  [eth_rx_pkg::MAC_W-1:0] mac_addr,
   input  wire                          rx_ack,
   output logic                         crc_init,
   output logic                         wr_en,
   output logic [BUF_ADDR_W-1:0]        wr_addr,
   output logic [7:0]                   wr_data,
   output logic                         rx_ready,
   output logic [BUF_ADDR_W-1:0]        nbytes,
   output logic [eth_rx_pkg::MAC_W-1:0] src_mac
);

   // room for header, full buffer and fcs
   localparam int CNT_W     = BUF_ADDR_W + 2;
   localparam int MAC_BYTES = eth_rx_pkg::MAC_W / 8;

   eth_rx_pkg::parse_state_t    state_q;
   logic [CNT_W-1:0]            cnt_q;
   logic [CNT_W-1:0]            frame_len;
   logic [BUF_ADDR_W-1:0]       pay_addr_q;
   logic [eth_rx_pkg::MAC_W-1:0] dest_q;
   logic [eth_rx_pkg::MAC_W-1:0] src_q;
   logic [15:0]                 len_q;
   logic [15:0]                 len_nxt;
   logic                        addr_hit;
   logic                        len_fits;
   logic                        accept;

   assign crc_init = frame_start;

   assign len_nxt  = {len_q[7:0], rx_byte};
   assign addr_hit = (dest_q == mac_addr) || (&dest_q);
   // length must fit in nbytes
   assign len_fits = (len_nxt >> BUF_ADDR_W) == 16'd0;

   assign frame_len = CNT_W'(eth_rx_pkg::HDR_BYTES + eth_rx_pkg::FCS_BYTES) + CNT_W'(len_q);
   assign accept    = frame_end && (state_q == eth_rx_pkg::FCS) && crc_ok &&
                      (cnt_q == frame_len);

   assign wr_en   = byte_valid && (state_q == eth_rx_pkg::PAYLOAD);
   assign wr_addr = pay_addr_q;
   assign wr_data = rx_byte;

   // cnt_q is the index of the byte being strobed
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state_q    <= eth_rx_pkg::IDLE;
         cnt_q      <= '0;
         pay_addr_q <= '0;
      end else if (frame_start) begin
         state_q    <= eth_rx_pkg::DEST;
         cnt_q      <= '0;
         pay_addr_q <= '0;
      end else if (frame_end) begin
         state_q <= eth_rx_pkg::IDLE;
      end else if (byte_valid && state_q != eth_rx_pkg::IDLE) begin
         // saturate so oversized frames never wrap onto a match
         if (!(&cnt_q)) begin
            cnt_q <= cnt_q + 1'b1;
         end
         case (state_q)
            eth_rx_pkg::DEST: begin
               if (cnt_q == CNT_W'(MAC_BYTES - 1)) begin
                  state_q <= eth_rx_pkg::SRC;
               end
            end
            eth_rx_pkg::SRC: begin
               if (cnt_q == CNT_W'(2 * MAC_BYTES - 1)) begin
                  state_q <= eth_rx_pkg::LEN;
               end
            end
            eth_rx_pkg::LEN: begin
               if (cnt_q == CNT_W'(eth_rx_pkg::HDR_BYTES - 1)) begin
                  if (!addr_hit || !len_fits || rx_ready) begin
                     state_q <= eth_rx_pkg::DROP;
                  end else if (len_nxt == 16'd0) begin
                     state_q <= eth_rx_pkg::FCS;
                  end else begin
                     state_q <= eth_rx_pkg::PAYLOAD;
                  end
               end
            end
            eth_rx_pkg::PAYLOAD: begin
               pay_addr_q <= pay_addr_q + 1'b1;
               if (pay_addr_q == BUF_ADDR_W'(len_q) - 1'b1) begin
                  state_q <= eth_rx_pkg::FCS;
               end
            end
            default: begin
            end
         endcase
      end
   end

   // header fields, msb first
   always_ff @(posedge RX_CLK) begin
      if (byte_valid) begin
         case (state_q)
            eth_rx_pkg::DEST: dest_q <= {dest_q[eth_rx_pkg::MAC_W-9:0], rx_byte};
            eth_rx_pkg::SRC:  src_q  <= {src_q[eth_rx_pkg::MAC_W-9:0], rx_byte};
            eth_rx_pkg::LEN:  len_q  <= len_nxt;
            default: begin
            end
         endcase
      end
   end

   // host status
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rx_ready <= 1'b0;
         nbytes   <= '0;
         src_mac  <= '0;
      end else if (accept) begin
         rx_ready <= 1'b1;
         nbytes   <= BUF_ADDR_W'(len_q);
         src_mac  <= src_q;
      end else if (rx_ack) begin
         rx_ready <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/eth_rx_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_rx_buffer #(
   parameter int BUF_ADDR_W = 11
) (
   input  wire                   RX_CLK,
   input  wire                   wr_en,
   input  wire  [BUF_ADDR_W-1:0] wr_addr,
   input  wire  [7:0]            wr_data,
   input  wire  [BUF_ADDR_W-1:0] rd_addr,
   output logic [7:0]            rd_data
);

   localparam int DEPTH = 2 ** BUF_ADDR_W;

   logic [7:0] mem [DEPTH];

   // parser side
   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // host side, one cycle read
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== verilog/eth_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_rx #(
   parameter int BUF_ADDR_W = 11
) (
   input  wire                          RX_CLK,
   input  wire                          rst,
   input  wire                          rx_dv,
   input  wire  [3:0]                   rx_data,
   input  wire  [eth_rx_pkg::MAC_W-1:0] mac_addr,
   input  wire                          rx_ack,
   input  wire  [BUF_ADDR_W-1:0]        rd_addr,
   output logic [7:0]                   rd_data,
   output logic                         rx_ready,
   output logic [BUF_ADDR_W-1:0]        nbytes,
   output logic [eth_rx_pkg::MAC_W-1:0] src_mac
);

   logic                  rx_rst;
   logic [7:0]            rx_byte;
   logic                  byte_valid;
   logic                  frame_start;
   logic                  frame_end;
   logic                  crc_init;
   logic                  crc_ok;
   logic                  wr_en;
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic [7:0]            wr_data;

   eth_mii_rx_frontend u_frontend (
      .RX_CLK      (RX_CLK),
      .rst         (rst),
      .rx_dv       (rx_dv),
      .rx_data     (rx_data),
      .rx_rst      (rx_rst),
      .rx_byte     (rx_byte),
      .byte_valid  (byte_valid),
      .frame_start (frame_start),
      .frame_end   (frame_end)
   );

   eth_crc32 u_crc (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .crc_init   (crc_init),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .crc_ok     (crc_ok)
   );

   eth_rx_parser #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_parser (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .frame_start (frame_start),
      .frame_end   (frame_end),
      .byte_valid  (byte_valid),
      .rx_byte     (rx_byte),
      .crc_ok      (crc_ok),
      .mac_addr    (mac_addr),
      .rx_ack      (rx_ack),
      .crc_init    (crc_init),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .rx_ready    (rx_ready),
      .nbytes      (nbytes),
      .src_mac     (src_mac)
   );

   eth_rx_buffer #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_buffer (
      .RX_CLK  (RX_CLK),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// ==== tests/eth_rx_frames.svh ====
`ifndef ETH_RX_FRAMES_SVH
`define ETH_RX_FRAMES_SVH

typedef logic [7:0] byte_q_t[$];

// bit serial ethernet fcs, already inverted
function automatic logic [31:0] fcs_of(input byte_q_t data);
   logic [31:0] crc;
   crc = 32'hFFFF_FFFF;
   foreach (data[i]) begin
      for (int b = 0; b < 8; b++) begin
         if (crc[0] ^ data[i][b]) begin
            crc = (crc >> 1) ^ 32'hEDB8_8320;
         end else begin
            crc = crc >> 1;
         end
      end
   end
   return ~crc;
endfunction

// preamble, sfd, header, payload, then fcs lsb first
function automatic byte_q_t frame_with_length(input logic [47:0] dest, input logic [47:0] src,
                                              input logic [15:0] len, input byte_q_t payload);
   byte_q_t     body;
   byte_q_t     frame;
   logic [31:0] fcs;
   for (int i = 5; i >= 0; i--) begin
      body.push_back(dest[8*i +: 8]);
   end
   for (int i = 5; i >= 0; i--) begin
      body.push_back(src[8*i +: 8]);
   end
   body.push_back(len[15:8]);
   body.push_back(len[7:0]);
   foreach (payload[i]) begin
      body.push_back(payload[i]);
   end
   fcs = fcs_of(body);
   for (int i = 0; i < 4; i++) begin
      body.push_back(fcs[8*i +: 8]);
   end
   repeat (7) begin
      frame.push_back(8'h55);
   end
   frame.push_back(8'hD5);
   foreach (body[i]) begin
      frame.push_back(body[i]);
   end
   return frame;
endfunction

// length field taken from the payload
function automatic byte_q_t build_frame(input logic [47:0] dest, input logic [47:0] src,
                                        input byte_q_t payload);
   return frame_with_length(dest, src, 16'(payload.size()), payload);
endfunction

function automatic byte_q_t make_payload(input int len, input int tag);
   byte_q_t p;
   for (int i = 0; i < len; i++) begin
      p.push_back(8'((i * 13 + tag * 37) & 255));
   end
   return p;
endfunction

function automatic byte_q_t random_payload(input int len);
   byte_q_t p;
   for (int i = 0; i < len; i++) begin
      p.push_back(8'($random(seed)));
   end
   return p;
endfunction

task automatic drive_nibble(input logic [3:0] nibble);
   @(posedge RX_CLK);
   #DRIVE_DLY;
   rx_dv   = 1'b1;
   rx_data = nibble;
endtask

// returns just after rx_dv drops
task automatic send_frame(input byte_q_t frame);
   foreach (frame[i]) begin
      drive_nibble(frame[i][3:0]);
      drive_nibble(frame[i][7:4]);
   end
   @(posedge RX_CLK);
   #DRIVE_DLY;
   rx_dv   = 1'b0;
   rx_data = 4'h0;
endtask

`endif

// ==== tests/eth_rx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_rx_tb;

   localparam int          BUF_ADDR_W = 11;
   localparam int          DRIVE_DLY  = 2;
   localparam logic [47:0] STATION    = 48'h02_00_5E_10_20_30;
   localparam logic [47:0] OTHER      = 48'h02_00_5E_10_20_31;
   localparam logic [47:0] BCAST      = 48'hFFFF_FFFF_FFFF;
   localparam logic [47:0] PEER       = 48'h02_11_22_33_44_55;

   logic                  RX_CLK;
   logic                  rst;
   logic                  rx_dv;
   logic [3:0]            rx_data;
   logic [47:0]           mac_addr;
   logic                  rx_ack;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [7:0]            rd_data;
   logic                  rx_ready;
   logic [BUF_ADDR_W-1:0] nbytes;
   logic [47:0]           src_mac;

   integer seed         = 98;
   int     cycles       = 0;
   int     cycle_limit  = 0;
   int     checks       = 0;
   int     test_errors  = 0;
   int     total_errors = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   int     rand_len[8];
   int     directed_len[8] = '{60, 46, 30, 50, 50, 40, 44, 36};

   `include "eth_rx_frames.svh"

   eth_rx #(.BUF_ADDR_W(BUF_ADDR_W)) DUT (
      .RX_CLK   (RX_CLK),
      .rst      (rst),
      .rx_dv    (rx_dv),
      .rx_data  (rx_data),
      .mac_addr (mac_addr),
      .rx_ack   (rx_ack),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .rx_ready (rx_ready),
      .nbytes   (nbytes),
      .src_mac  (src_mac)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #20 RX_CLK = ~RX_CLK;
   end

   always @(posedge RX_CLK) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   // two nibbles per byte plus read back, ack and idle
   function automatic int frame_cycles(input int len);
      return 2 * (26 + len) + len + 40;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      assert (actual === expected)
      else begin
         $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1)
      else begin
         $display("Error at %0t: %s", $time, what);
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
         tests_failed++;
         total_errors += test_errors;
      end
      test_errors = 0;
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!rx_ready && n < 3) begin
         @(posedge RX_CLK);
         #DRIVE_DLY;
         n++;
      end
      check_true(rx_ready, "rx_ready did not rise within 3 cycles of the last nibble");
   endtask

   // rx_ready must hold its level for n cycles
   task automatic watch_ready(input int n, input logic level, input string what);
      logic moved;
      moved = 1'b0;
      repeat (n) begin
         @(posedge RX_CLK);
         #DRIVE_DLY;
         moved = moved | (rx_ready !== level);
      end
      check_true(!moved, what);
   endtask

   task automatic read_back(input byte_q_t payload);
      rd_addr = '0;
      foreach (payload[i]) begin
         @(posedge RX_CLK);
         #DRIVE_DLY;
         check_value($sformatf("rd_data[%0d]", i), 64'(payload[i]), 64'(rd_data));
         rd_addr = BUF_ADDR_W'(i + 1);
      end
   endtask

   task automatic pulse_ack();
      @(posedge RX_CLK);
      #DRIVE_DLY;
      rx_ack = 1'b1;
      @(posedge RX_CLK);
      #DRIVE_DLY;
      rx_ack = 1'b0;
      check_value("rx_ready", 64'd0, 64'(rx_ready));
   endtask

   task automatic receive_good(input logic [47:0] dest, input logic [47:0] src,
                               input byte_q_t payload, input logic ack);
      byte_q_t frame;
      frame = build_frame(dest, src, payload);
      send_frame(frame);
      wait_ready();
      check_value("nbytes", 64'(payload.size()), 64'(nbytes));
      check_value("src_mac", 64'(src), 64'(src_mac));
      read_back(payload);
      if (ack) begin
         pulse_ack();
      end
   endtask

   initial begin
      byte_q_t p;
      byte_q_t kept;
      byte_q_t frame;
      rst      = 1'b1;
      rx_dv    = 1'b0;
      rx_data  = 4'h0;
      mac_addr = STATION;
      rx_ack   = 1'b0;
      rd_addr  = '0;
      cycle_limit = 100;
      for (int i = 0; i < 8; i++) begin
         rand_len[i] = 1 + int'($unsigned($random(seed)) % 1500);
         cycle_limit += frame_cycles(rand_len[i]) + frame_cycles(directed_len[i]);
      end
      cycle_limit += frame_cycles(directed_len[4]);

      repeat (16) @(posedge RX_CLK);
      #DRIVE_DLY;
      rst = 1'b0;
      repeat (4) @(posedge RX_CLK);
      #DRIVE_DLY;
      check_value("rx_ready", 64'd0, 64'(rx_ready));
      check_value("nbytes", 64'd0, 64'(nbytes));
      check_value("src_mac", 64'd0, 64'(src_mac));
      finish_test("reset state");

      p = make_payload(directed_len[0], 1);
      receive_good(STATION, PEER, p, 1'b1);
      finish_test("good unicast frame");

      kept = make_payload(directed_len[1], 2);
      receive_good(BCAST, PEER ^ 48'h1, kept, 1'b1);
      frame = build_frame(OTHER, PEER ^ 48'h2, make_payload(directed_len[2], 3));
      send_frame(frame);
      watch_ready(8, 1'b0, "rx_ready rose for a frame to a foreign address");
      check_value("nbytes", 64'(directed_len[1]), 64'(nbytes));
      check_value("src_mac", 64'(PEER ^ 48'h1), 64'(src_mac));
      read_back(kept);
      finish_test("broadcast and foreign unicast");

      // one payload bit flipped after the fcs was computed
      frame = build_frame(STATION, PEER, make_payload(directed_len[3], 4));
      frame[8 + 14 + 10] = frame[8 + 14 + 10] ^ 8'h08;
      send_frame(frame);
      watch_ready(8, 1'b0, "rx_ready rose for a frame with a bad fcs");
      frame = build_frame(STATION, PEER, make_payload(directed_len[4], 5));
      void'(frame.pop_back());
      send_frame(frame);
      watch_ready(8, 1'b0, "rx_ready rose for a frame with a truncated fcs");
      // good fcs but one byte shorter than its length field
      frame = frame_with_length(STATION, PEER, 16'(directed_len[4] + 1),
                                make_payload(directed_len[4], 5));
      send_frame(frame);
      watch_ready(8, 1'b0, "rx_ready rose for a frame shorter than its length field");
      check_value("nbytes", 64'(directed_len[1]), 64'(nbytes));
      finish_test("corrupted frames");

      kept = make_payload(directed_len[5], 6);
      receive_good(STATION, PEER, kept, 1'b0);
      frame = build_frame(STATION, PEER ^ 48'h3, make_payload(directed_len[6], 7));
      send_frame(frame);
      watch_ready(8, 1'b1, "rx_ready dropped while a frame was waiting for the host");
      check_value("nbytes", 64'(directed_len[5]), 64'(nbytes));
      check_value("src_mac", 64'(PEER), 64'(src_mac));
      read_back(kept);
      pulse_ack();
      receive_good(STATION, PEER ^ 48'h4, make_payload(directed_len[7], 8), 1'b1);
      finish_test("frame while not acknowledged");

      for (int i = 0; i < 8; i++) begin
         p = random_payload(rand_len[i]);
         receive_good(STATION, PEER ^ 48'(i + 16), p, 1'b1);
      end
      finish_test("random payloads");

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
verilog/eth_rx_pkg.sv
verilog/eth_mii_rx_frontend.sv
verilog/eth_crc32.sv
verilog/eth_rx_parser.sv
verilog/eth_rx_buffer.sv
verilog/eth_rx.sv
tests/eth_rx_tb.sv

// ==== Makefile ====
# Verilator build and run of the MII receive path testbench

VERILATOR ?= verilator
TOP       ?= eth_rx_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0

FAIL_MSG := \*\* FAIL \*\*
PASS_MSG := \*\* PASS \*\*

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG) || ! grep -q '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
